// File: logic/jpeg_out_pkg.sv
//////////////////////////////////////////////////
// widths and constants for the JPEG output stage; codes are right aligned,
// the stream goes out most significant bit first
//////////////////////////////////////////////////
package jpeg_out_pkg;

    // a single Huffman codeword, or one packed 32-bit word
    typedef logic [31:0] code_t;

    // codeword length, 1 to 32 bits
    typedef logic [5:0] code_len_t;

    typedef logic [7:0] byte_t;

    // frame end pads the pending bits with ones
    localparam code_len_t FILL_LENGTH = 6'd32;
    localparam code_t     FILL_CODE   = 32'hffff_ffff;

    // an FF in the entropy coded data must be followed by 00
    localparam byte_t STUFF_MARKER = 8'hff;
    localparam byte_t STUFF_BYTE   = 8'h00;

    typedef enum logic [1:0] {
        idle,
        flush,
        clear
    } flush_state_t;

endpackage

// File: logic/packer_in_if.sv
//////////////////////////////////////////////////
// codeword link into the packer; valid is never high while clear is high
//////////////////////////////////////////////////
interface packer_in_if;

    logic                   valid;
    jpeg_out_pkg::code_t     data;
    logic                    clear;
    jpeg_out_pkg::code_len_t length;

    modport ctrl (
        output valid,
        output data,
        output length,
        output clear
    );

    modport packer (
        input valid,
        input data,
        input length,
        input clear
    );

endinterface

// File: logic/flush_control.sv
//////////////////////////////////////////////////
// codes pass through combinationally while idle; frame_done_i must stay
// high until the flush has drained
//////////////////////////////////////////////////
module flush_control (
    input  logic                    clock,
    input  logic                    nreset,
    input  logic                    code_valid_i,
    input  jpeg_out_pkg::code_t     code_i,
    input  jpeg_out_pkg::code_len_t code_length_i,
    input  logic                    frame_done_i,
    packer_in_if.ctrl               pack
);

    jpeg_out_pkg::flush_state_t state;
    jpeg_out_pkg::flush_state_t state_next;

    always_comb begin
        state_next  = state;
        pack.valid  = 1'b0;
        pack.data   = code_i;
        pack.length = code_length_i;
        pack.clear  = 1'b0;

        case (state)
            jpeg_out_pkg::idle: begin
                pack.valid = code_valid_i;
                if (frame_done_i) begin
                    state_next = jpeg_out_pkg::flush;
                end
            end

            // one full word of ones pushes every pending bit out of the packer
            jpeg_out_pkg::flush: begin
                pack.valid  = 1'b1;
                pack.data   = jpeg_out_pkg::FILL_CODE;
                pack.length = jpeg_out_pkg::FILL_LENGTH;
                state_next  = jpeg_out_pkg::clear;
            end

            // leftover fill bits are thrown away here
            jpeg_out_pkg::clear: begin
                pack.clear = 1'b1;
                if (!frame_done_i) begin
                    state_next = jpeg_out_pkg::idle;
                end
            end

            default: begin
                state_next = jpeg_out_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (nreset) begin
            state <= jpeg_out_pkg::idle;
        end else begin
            state <= state_next;
        end
    end

endmodule

// File: logic/bit_packer.sv
//////////////////////////////////////////////////
// packs 1 to 32 bit codes MSB first into 32-bit words; at most one
// word leaves per code, so codes need the input spacing
//////////////////////////////////////////////////
module bit_packer (
    input  logic                clock,
    input  logic                nreset,
    packer_in_if.packer         pack,
    output logic                word_valid_o,
    output jpeg_out_pkg::code_t word_o
);

    localparam int word_bits = $bits(jpeg_out_pkg::code_t);

    // pending bits sit left aligned at the top of the accumulator
    logic [2*word_bits-1:0]  acc;
    jpeg_out_pkg::code_len_t fill_count;

    jpeg_out_pkg::code_len_t align_shift;
    jpeg_out_pkg::code_t     code_aligned;
    logic [2*word_bits-1:0]  merged;
    logic [6:0]              total;
    logic                    word_full;

    //////////////////////////////////////////////////
    // merge the new code below the pending bits

    // shifting left drops any stray bits above the code length
    assign align_shift  = 6'(word_bits) - pack.length;
    assign code_aligned = pack.data << align_shift;

    assign merged    = acc | ({code_aligned, {word_bits{1'b0}}} >> fill_count);
    assign total     = {1'b0, fill_count} + {1'b0, pack.length};
    assign word_full = pack.valid && (total >= 7'(word_bits));

    //////////////////////////////////////////////////
    // accumulator and fill count

    always_ff @(posedge clock) begin
        if (nreset || pack.clear) begin
            acc          <= '0;
            fill_count   <= '0;
            word_valid_o <= 1'b0;
        end else begin
            word_valid_o <= word_full;
            if (word_full) begin
                // the overflow beyond 32 bits moves up to start the next word
                acc        <= {merged[word_bits-1:0], {word_bits{1'b0}}};
                fill_count <= 6'(total - 7'(word_bits));
            end else if (pack.valid) begin
                acc        <= merged;
                fill_count <= total[5:0];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (word_full) begin
            word_o <= merged[2*word_bits-1 -: word_bits];
        end
    end

endmodule

// File: logic/byte_serializer.sv
//////////////////////////////////////////////////
// four bytes per word, MSB first, on alternate cycles; a new word
// restarts the sequence, so words must be 8 or more cycles apart
//////////////////////////////////////////////////
module byte_serializer (
    input  logic                clock,
    input  logic                nreset,
    input  logic                word_valid_i,
    input  jpeg_out_pkg::code_t word_i,
    output logic                raw_valid_o,
    output jpeg_out_pkg::byte_t raw_byte_o
);

    jpeg_out_pkg::code_t word_q;
    logic                busy;
    logic [1:0]          byte_index;
    logic                phase;

    always_ff @(posedge clock) begin
        if (nreset) begin
            busy       <= 1'b0;
            byte_index <= 2'd0;
            phase      <= 1'b0;
        end else if (word_valid_i) begin
            busy       <= 1'b1;
            byte_index <= 2'd0;
            phase      <= 1'b0;
        end else if (busy) begin
            // the idle phase leaves a slot for a stuffed 00 behind each byte
            phase <= ~phase;
            if (phase) begin
                byte_index <= byte_index + 2'd1;
            end
            if (!phase && (byte_index == 2'd3)) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (word_valid_i) begin
            word_q <= word_i;
        end
    end

    assign raw_valid_o = busy && !phase;

    // byte 0 is bits 31:24, so the offset is (3 - index) * 8
    assign raw_byte_o = word_q[{~byte_index, 3'b000} +: 8];

endmodule

// File: logic/byte_stuffer.sv
//////////////////////////////////////////////////
// adds 00 after each FF; the stuffed byte takes the gap cycle that
// follows every input byte
//////////////////////////////////////////////////
module byte_stuffer (
    input  logic                clock,
    input  logic                nreset,
    input  logic                raw_valid_i,
    input  jpeg_out_pkg::byte_t raw_byte_i,
    output logic                byte_valid_o,
    output jpeg_out_pkg::byte_t byte_o
);

    logic stuff_pending;

    always_ff @(posedge clock) begin
        if (nreset) begin
            byte_valid_o  <= 1'b0;
            stuff_pending <= 1'b0;
        end else if (raw_valid_i) begin
            byte_valid_o  <= 1'b1;
            stuff_pending <= (raw_byte_i == jpeg_out_pkg::STUFF_MARKER);
        end else if (stuff_pending) begin
            byte_valid_o  <= 1'b1;
            stuff_pending <= 1'b0;
        end else begin
            byte_valid_o <= 1'b0;
        end
    end

    // data path follows the same priority as the valid above
    always_ff @(posedge clock) begin
        if (raw_valid_i) begin
            byte_o <= raw_byte_i;
        end else if (stuff_pending) begin
            byte_o <= jpeg_out_pkg::STUFF_BYTE;
        end
    end

endmodule

// File: logic/frame_sync.sv
//////////////////////////////////////////////////
// frame_active_o is a timeout, not a true drain check; pipeline_lifetime
// has to cover the flush path, 32 cycles or more
//////////////////////////////////////////////////
module frame_sync #(
    parameter int pipeline_lifetime = 256
) (
    input  logic clock,
    input  logic nreset,
    input  logic word_valid_i,
    input  logic frame_done_i,
    output logic frame_active_o
);

    localparam int count_bits = $clog2(pipeline_lifetime + 1);

    logic [count_bits-1:0] done_count;
    logic                  drained;

    assign drained = (done_count == count_bits'(pipeline_lifetime));

    // counts cycles since frame end and holds at the limit
    always_ff @(posedge clock) begin
        if (nreset || !frame_done_i) begin
            done_count <= '0;
        end else if (!drained) begin
            done_count <= done_count + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (nreset) begin
            frame_active_o <= 1'b0;
        end else if (word_valid_i) begin
            frame_active_o <= 1'b1;
        end else if (drained) begin
            frame_active_o <= 1'b0;
        end
    end

endmodule

// File: logic/jpeg_output_stage.sv
//////////////////////////////////////////////////
// no back-pressure; code strobes and frame_done_i must be spaced by
// 8 cycles or more
//////////////////////////////////////////////////
module jpeg_output_stage #(
    parameter int pipeline_lifetime = 256
) (
    input  logic                    clock,
    input  logic                    nreset,
    input  logic                    code_valid_i,
    input  jpeg_out_pkg::code_t     code_i,
    input  jpeg_out_pkg::code_len_t code_length_i,
    input  logic                    frame_done_i,
    output logic                    byte_valid_o,
    output jpeg_out_pkg::byte_t     byte_o,
    output logic                    frame_active_o
);

    packer_in_if pack_if ();

    logic                word_valid;
    jpeg_out_pkg::code_t word;
    logic                raw_valid;
    jpeg_out_pkg::byte_t raw_byte;

    //////////////////////////////////////////////////
    // codes to words

    flush_control flush_control_i (
        .clock         (clock),
        .nreset        (nreset),
        .code_valid_i  (code_valid_i),
        .code_i        (code_i),
        .code_length_i (code_length_i),
        .frame_done_i  (frame_done_i),
        .pack          (pack_if.ctrl)
    );

    bit_packer bit_packer_i (
        .clock        (clock),
        .nreset       (nreset),
        .pack         (pack_if.packer),
        .word_valid_o (word_valid),
        .word_o       (word)
    );

    //////////////////////////////////////////////////
    // words to the byte stream

    byte_serializer byte_serializer_i (
        .clock        (clock),
        .nreset       (nreset),
        .word_valid_i (word_valid),
        .word_i       (word),
        .raw_valid_o  (raw_valid),
        .raw_byte_o   (raw_byte)
    );

    byte_stuffer byte_stuffer_i (
        .clock        (clock),
        .nreset       (nreset),
        .raw_valid_i  (raw_valid),
        .raw_byte_i   (raw_byte),
        .byte_valid_o (byte_valid_o),
        .byte_o       (byte_o)
    );

    frame_sync #(
        .pipeline_lifetime (pipeline_lifetime)
    ) frame_sync_i (
        .clock          (clock),
        .nreset         (nreset),
        .word_valid_i   (word_valid),
        .frame_done_i   (frame_done_i),
        .frame_active_o (frame_active_o)
    );

endmodule

// File: verif/jpeg_output_stage_tb.sv
//////////////////////////////////////////////////
// random codes in four frames against a bit-stream model; frame 2 sends
// only ones, frame 3 ends word aligned; default pipeline_lifetime only
//////////////////////////////////////////////////
module jpeg_output_stage_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int lifetime       = 256;
    localparam int num_frames     = 4;
    localparam int timeout_cycles = num_frames * (80 * 12 + lifetime + 100);

    logic                    clock;
    logic                    nreset;
    logic                    code_valid_i;
    jpeg_out_pkg::code_t     code_i;
    jpeg_out_pkg::code_len_t code_length_i;
    logic                    frame_done_i;
    logic                    byte_valid_o;
    jpeg_out_pkg::byte_t     byte_o;
    logic                    frame_active_o;

    logic [31:0] rand_state;
    bit          model_bits[$];
    logic [7:0]  expected_bytes[$];
    logic [7:0]  expected_byte;
    logic        last_was_marker;
    int          frame_bits;
    int          mismatch_count;
    int          failure_count;
    int          byte_count;
    int          cycle_count;

    jpeg_output_stage dut_i (
        .clock          (clock),
        .nreset         (nreset),
        .code_valid_i   (code_valid_i),
        .code_i         (code_i),
        .code_length_i  (code_length_i),
        .frame_done_i   (frame_done_i),
        .byte_valid_o   (byte_valid_o),
        .byte_o         (byte_o),
        .frame_active_o (frame_active_o)
    );

    always #10 clock = ~clock;

    //////////////////////////////////////////////////
    // random numbers and the reference model

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic int random_range(input int lo, input int hi);
        return lo + int'((next_random() >> 8) % 32'(hi - lo + 1));
    endfunction

    // every eight bits form a byte; an FF byte is followed by a stuffed 00
    task automatic append_model_bit(input bit b);
        logic [7:0] value;
        int         i;
        model_bits.push_back(b);
        frame_bits++;
        if (model_bits.size() == 8) begin
            value = '0;
            for (i = 0; i < 8; i++) begin
                value = {value[6:0], model_bits[i]};
            end
            model_bits.delete();
            expected_bytes.push_back(value);
            if (value == 8'hff) begin
                expected_bytes.push_back(8'h00);
            end
        end
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic send_code(input logic [31:0] code, input int len);
        int i;
        code_valid_i  = 1'b1;
        code_i        = code;
        code_length_i = 6'(len);
        for (i = len - 1; i >= 0; i--) begin
            append_model_bit(code[i]);
        end
        next_cycle();
        code_valid_i = 1'b0;
    endtask

    task automatic run_frame(input int frame_index);
        int          num_codes;
        int          len;
        int          pad;
        int          n;
        logic [31:0] code;
        frame_bits = 0;
        num_codes  = random_range(40, 80);
        for (n = 0; n < num_codes; n++) begin
            len  = random_range(1, 32);
            code = next_random();
            if (frame_index == 2) begin
                code = '1;
            end
            // the last frame closes on a word boundary so a whole fill word goes out
            if (frame_index == 3 && n == num_codes - 1) begin
                len = 32 - (frame_bits % 32);
            end
            send_code(code, len);
            if (n < num_codes - 1) begin
                repeat (random_range(8, 12) - 1) next_cycle();
            end
        end
        // frame end comes 10 cycles after the last strobe
        repeat (9) next_cycle();

        pad = (frame_bits % 32 == 0) ? 32 : 32 - (frame_bits % 32);
        repeat (pad) append_model_bit(1'b1);

        frame_done_i = 1'b1;
        repeat (lifetime + 2) next_cycle();
        if (frame_active_o !== 1'b0) begin
            $display("Mismatch at %0t: frame_active_o expected 0 got %b", $time, frame_active_o);
            mismatch_count++;
        end
        repeat (18) next_cycle();
        frame_done_i = 1'b0;
        repeat (10) next_cycle();

        if (expected_bytes.size() != 0) begin
            $display("Frame %0d ended with %0d expected bytes never received",
                     frame_index, expected_bytes.size());
            failure_count++;
            expected_bytes.delete();
        end
    endtask

    //////////////////////////////////////////////////
    // outputs are checked on the falling edge

    always @(negedge clock) begin
        if (!nreset && byte_valid_o) begin
            if (!frame_active_o) begin
                $display("At %0t a byte appeared while frame_active_o was low", $time);
                failure_count++;
            end
            if (last_was_marker && byte_o !== 8'h00) begin
                $display("At %0t an FF byte was not followed by a stuffed 00", $time);
                failure_count++;
            end
            last_was_marker = (byte_o == 8'hff);
            if (expected_bytes.size() == 0) begin
                $display("At %0t byte %02h arrived with no byte expected", $time, byte_o);
                failure_count++;
            end else begin
                expected_byte = expected_bytes.pop_front();
                byte_count++;
                if (byte_o !== expected_byte) begin
                    $display("Mismatch at %0t: byte_o expected %02h got %02h",
                             $time, expected_byte, byte_o);
                    mismatch_count++;
                end
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            $display("Timeout after %0d cycles, the stimulus did not complete", cycle_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        clock           = 1'b0;
        nreset          = 1'b1;
        code_valid_i    = 1'b0;
        code_i          = '0;
        code_length_i   = '0;
        frame_done_i    = 1'b0;
        rand_state      = 32'h8e5;
        last_was_marker = 1'b0;
        frame_bits      = 0;
        mismatch_count  = 0;
        failure_count   = 0;
        byte_count      = 0;
        cycle_count     = 0;

        repeat (8) @(posedge clock);
        #2;
        nreset = 1'b0;

        // nothing may come out before the first code
        repeat (10) begin
            next_cycle();
            if (byte_valid_o !== 1'b0) begin
                $display("Mismatch at %0t: byte_valid_o expected 0 got %b", $time, byte_valid_o);
                mismatch_count++;
            end
            if (frame_active_o !== 1'b0) begin
                $display("Mismatch at %0t: frame_active_o expected 0 got %b",
                         $time, frame_active_o);
                mismatch_count++;
            end
        end

        for (int f = 0; f < num_frames; f++) begin
            run_frame(f);
        end

        $display("%0d bytes checked, %0d mismatches, %0d other errors",
                 byte_count, mismatch_count, failure_count);
        if (mismatch_count + failure_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: sources.f
logic/jpeg_out_pkg.sv
logic/packer_in_if.sv
logic/flush_control.sv
logic/bit_packer.sv
logic/byte_serializer.sv
logic/byte_stuffer.sv
logic/frame_sync.sv
logic/jpeg_output_stage.sv
verif/jpeg_output_stage_tb.sv

// File: Bender.yml
package:
  name: jpeg_output_stage

sources:
  - files:
      - logic/jpeg_out_pkg.sv
      - logic/packer_in_if.sv
      - logic/flush_control.sv
      - logic/bit_packer.sv
      - logic/byte_serializer.sv
      - logic/byte_stuffer.sv
      - logic/frame_sync.sv
      - logic/jpeg_output_stage.sv
  - target: test
    files:
      - verif/jpeg_output_stage_tb.sv
